// ==== flist.f ====
verilog/uart_io_pkg.sv
verilog/reset_stretch.sv
verilog/tx_credit_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/rx_cmd_decode.sv
verilog/uart_io_top.sv
verif/uart_io_checker.sv
verif/uart_io_tb.sv

// ==== verif/uart_io_tb.sv ====
module uart_io_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_io_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int RST_CYCLES   = 16;
    localparam int RST_LOW      = 4;

    // bytes per phase
    localparam int N_DATA  = 200;
    localparam int N_MIX   = 60;
    localparam int N_BURST = 16;
    localparam int N_LOST  = 6;
    localparam int N_TAIL  = 18;
    localparam int N_TOTAL = N_DATA + N_MIX + N_BURST + N_LOST + N_TAIL;
    // one frame per byte plus margin for gaps and resets
    localparam int MAX_CYCLES = N_TOTAL * 10 * CLKS_PER_BIT * 5 / 3;

    logic              clk;
    logic              i_rst_n;
    logic              i_tx_valid;
    logic [DATA_W-1:0] i_tx_data;
    logic              o_tx_credit;
    // tx looped straight back into rx
    logic              uart_line;
    logic              o_rx_valid;
    logic [DATA_W-1:0] o_rx_data;
    logic [LED_W-1:0]  o_led;
    logic              o_ready;

    // expected bytes in flight and the led value each one leaves behind
    logic [DATA_W-1:0] exp_byte_q[$];
    logic [LED_W-1:0]  exp_led_q[$];
    logic [LED_W-1:0]  gen_led;
    logic [LED_W-1:0]  seen_led;
    int                credits;
    int                min_credits;
    int                credit_pulses;
    int                bytes_written;
    logic              mon_en;
    int                err_data;
    int                err_led;
    int                err_reset;
    int                err_other;
    int                cycles;

    uart_io_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .RST_CYCLES   (RST_CYCLES)
    ) dut_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_tx_valid  (i_tx_valid),
        .i_tx_data   (i_tx_data),
        .o_tx_credit (o_tx_credit),
        .i_uart_rx   (uart_line),
        .o_uart_tx   (uart_line),
        .o_rx_valid  (o_rx_valid),
        .o_rx_data   (o_rx_data),
        .o_led       (o_led),
        .o_ready     (o_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // led rules per opcode
    function automatic logic [LED_W-1:0] led_after(input logic [LED_W-1:0] led,
                                                   input cmd_op_e op,
                                                   input logic [LED_W-1:0] mask);
        logic [LED_W-1:0] res;
        case (op)
            OP_SET:    res = led | mask;
            OP_CLEAR:  res = led & ~mask;
            OP_TOGGLE: res = led ^ mask;
            default:   res = mask;
        endcase
        return res;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // block until a credit is held and present one byte for a cycle
    task automatic write_byte(input logic [DATA_W-1:0] b, input logic [LED_W-1:0] led);
        while (credits == 0)
        begin
            @(posedge clk);
            #1;
        end
        i_tx_valid = 1'b1;
        i_tx_data  = b;
        credits--;
        if (credits < min_credits)
        begin
            min_credits = credits;
        end
        bytes_written++;
        exp_byte_q.push_back(b);
        exp_led_q.push_back(led);
        @(posedge clk);
        #1;
        i_tx_valid = 1'b0;
    endtask

    task automatic send_data();
        write_byte(DATA_W'($urandom_range(0, 127)), gen_led);
    endtask

    // random command re-drawn until it changes the leds
    task automatic send_cmd();
        rx_word_u         w;
        logic [LED_W-1:0] next;
        w.raw = '0;
        do
        begin
            w.cmd.is_cmd = 1'b1;
            w.cmd.op     = cmd_op_e'($urandom_range(0, 3));
            w.cmd.rsvd   = 1'($urandom);
            w.cmd.mask   = LED_W'($urandom);
            next         = led_after(gen_led, w.cmd.op, w.cmd.mask);
        end
        while (next == gen_led);
        gen_led = next;
        write_byte(w.raw, next);
    endtask

    task automatic check_reset_outputs();
        assert (uart_line === 1'b1)
        else
        begin
            err_reset++;
            $display("[FAIL] %0t o_uart_tx expected 1 got %b", $time, uart_line);
        end
        assert (o_led === '0)
        else
        begin
            err_reset++;
            $display("[FAIL] %0t o_led expected 0 got %h", $time, o_led);
        end
        assert (o_rx_valid === 1'b0)
        else
        begin
            err_reset++;
            $display("[FAIL] %0t o_rx_valid expected 0 got %b", $time, o_rx_valid);
        end
        assert (o_tx_credit === 1'b0)
        else
        begin
            err_reset++;
            $display("[FAIL] %0t o_tx_credit expected 0 got %b", $time, o_tx_credit);
        end
    endtask

    // board reset for 4 cycles and a count of cycles up to ready
    task automatic do_reset();
        int n;
        mon_en = 1'b0;
        i_rst_n    = 1'b0;
        i_tx_valid = 1'b0;
        exp_byte_q.delete();
        exp_led_q.delete();
        gen_led       = '0;
        seen_led      = '0;
        credit_pulses = 0;
        bytes_written = 0;
        for (int i = 0; i < RST_LOW; i++)
        begin
            @(posedge clk);
            #1;
            // internal reset lags the board reset by a cycle
            if (i >= 2)
            begin
                check_reset_outputs();
            end
        end
        i_rst_n = 1'b1;
        // first edge that samples the release
        @(posedge clk);
        #1;
        n = 0;
        while (!o_ready && n < RST_CYCLES + 8)
        begin
            check_reset_outputs();
            @(posedge clk);
            #1;
            n++;
        end
        assert (n == RST_CYCLES)
        else
        begin
            err_reset++;
            $display("[FAIL] %0t o_ready cycles expected %0d got %0d", $time, RST_CYCLES, n);
        end
        credits     = FIFO_DEPTH;
        min_credits = FIFO_DEPTH;
        mon_en      = 1'b1;
    endtask

    // wait until every byte has come back over the loop
    task automatic drain();
        while (exp_byte_q.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
        // every byte left the queue before it hit the line
        assert (credit_pulses == bytes_written)
        else
        begin
            err_other++;
            $display("[FAIL] %0t o_tx_credit pulses expected %0d got %0d",
                     $time, bytes_written, credit_pulses);
        end
        assert (o_led === gen_led)
        else
        begin
            err_led++;
            $display("[FAIL] %0t o_led expected %h got %h", $time, gen_led, o_led);
        end
    endtask

    task automatic check_rx_byte();
        logic [DATA_W-1:0] b;
        logic [LED_W-1:0]  l;
        assert (exp_byte_q.size() != 0)
        else
        begin
            err_other++;
            $display("%0t: o_rx_valid pulsed with no byte outstanding", $time);
        end
        if (exp_byte_q.size() != 0)
        begin
            b = exp_byte_q.pop_front();
            l = exp_led_q.pop_front();
            assert (!b[DATA_W-1])
            else
            begin
                err_other++;
                $display("%0t: o_rx_valid pulsed where command %02h (leds %h) was due",
                         $time, b, l);
            end
            assert (o_rx_data === b)
            else
            begin
                err_data++;
                $display("[FAIL] %0t o_rx_data expected %02h got %02h", $time, b, o_rx_data);
            end
        end
    endtask

    task automatic check_led_change();
        logic [DATA_W-1:0] b;
        logic [LED_W-1:0]  l;
        assert (exp_byte_q.size() != 0)
        else
        begin
            err_other++;
            $display("%0t: o_led changed with no byte outstanding", $time);
        end
        if (exp_byte_q.size() != 0)
        begin
            b = exp_byte_q.pop_front();
            l = exp_led_q.pop_front();
            assert (b[DATA_W-1])
            else
            begin
                err_other++;
                $display("%0t: o_led changed where data byte %02h was due", $time, b);
            end
            assert (o_led === l)
            else
            begin
                err_led++;
                $display("[FAIL] %0t o_led expected %h got %h", $time, l, o_led);
            end
        end
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk)
    begin
        if (mon_en)
        begin
            if (o_tx_credit)
            begin
                credit_pulses++;
                credits++;
                assert (credits <= FIFO_DEPTH)
                else
                begin
                    err_other++;
                    $display("%0t: credit returned with none outstanding", $time);
                end
            end
            if (o_rx_valid)
            begin
                check_rx_byte();
            end
            if (o_led !== seen_led)
            begin
                check_led_change();
                seen_led = o_led;
            end
        end
    end

    // cycle limit
    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        err_other++;
        $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: data %0d, led %0d, reset %0d, other %0d, checker %0d",
                 err_data, err_led, err_reset, err_other, dut_i.chk_i.fail_count);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        i_rst_n    = 1'b0;
        i_tx_valid = 1'b0;
        i_tx_data  = '0;
        mon_en     = 1'b0;
        credits    = 0;
        err_data   = 0;
        err_led    = 0;
        err_reset  = 0;
        err_other  = 0;
        void'($urandom(30080));
        do_reset();

        // plain data at random gaps
        for (int i = 0; i < N_DATA; i++)
        begin
            send_data();
            idle_cycles($urandom_range(0, 30));
        end
        drain();

        // roughly one command in four
        for (int i = 0; i < N_MIX; i++)
        begin
            if ($urandom_range(0, 3) == 0)
            begin
                send_cmd();
            end
            else
            begin
                send_data();
            end
            idle_cycles($urandom_range(0, 6));
        end
        drain();

        // back to back writes run the queue full
        min_credits = FIFO_DEPTH;
        for (int i = 0; i < N_BURST; i++)
        begin
            send_data();
        end
        assert (min_credits == 0)
        else
        begin
            err_other++;
            $display("%0t: burst never used up all credits", $time);
        end
        drain();

        // reset with bytes still in flight
        for (int i = 0; i < N_LOST; i++)
        begin
            send_data();
        end
        idle_cycles(10 * CLKS_PER_BIT + $urandom_range(0, 40));
        do_reset();
        for (int i = 0; i < N_TAIL; i++)
        begin
            send_data();
            idle_cycles($urandom_range(0, 30));
        end
        drain();

        $display("errors: data %0d, led %0d, reset %0d, other %0d, checker %0d",
                 err_data, err_led, err_reset, err_other, dut_i.chk_i.fail_count);
        if (err_data + err_led + err_reset + err_other + dut_i.chk_i.fail_count == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verif/uart_io_checker.sv ====
module uart_io_checker (
    input logic clk,
    input logic i_rst_n,
    input logic i_wr_valid,
    input logic i_fifo_full,
    input logic i_tx_credit,
    input logic i_tx_busy,
    input logic i_uart_tx,
    input logic i_rx_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // assertion failures so far
    int fail_count = 0;

    // core has to hold off while the queue is full
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_wr_valid |-> !i_fifo_full
    )
    else
    begin
        fail_count++;
        $error("write presented while the transmit FIFO is full");
    end

    // each credit hands one byte to the transmitter, which is busy next cycle
    a_credit_pulse: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_tx_credit |=> (i_tx_busy && !i_tx_credit)
    )
    else
    begin
        fail_count++;
        $error("o_tx_credit not a single pulse into a busy transmitter");
    end

    // line idles high between frames
    a_line_idle: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !i_tx_busy |-> i_uart_tx
    )
    else
    begin
        fail_count++;
        $error("o_uart_tx low while the transmitter is idle");
    end

    // at most one byte per frame
    a_rx_pulse: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_rx_valid |=> !i_rx_valid
    )
    else
    begin
        fail_count++;
        $error("o_rx_valid high on two cycles in a row");
    end

endmodule

// hooked onto internal nets of the top level
bind uart_io_top uart_io_checker chk_i (
    .clk         (clk),
    .i_rst_n     (rst_int_n),
    .i_wr_valid  (i_tx_valid),
    .i_fifo_full (u_fifo.full),
    .i_tx_credit (o_tx_credit),
    .i_tx_busy   (tx_busy),
    .i_uart_tx   (o_uart_tx),
    .i_rx_valid  (o_rx_valid)
);

// ==== verilog/uart_io_top.sv ====
module uart_io_top #(
    parameter int CLKS_PER_BIT = 104,
    parameter int FIFO_DEPTH   = 8,
    parameter int RST_CYCLES   = 16
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_tx_valid,
    input  logic [uart_io_pkg::DATA_W-1:0] i_tx_data,
    output logic                           o_tx_credit,
    input  logic                           i_uart_rx,
    output logic                           o_uart_tx,
    output logic                           o_rx_valid,
    output logic [uart_io_pkg::DATA_W-1:0] o_rx_data,
    output logic [uart_io_pkg::LED_W-1:0]  o_led,
    output logic                           o_ready
);

    import uart_io_pkg::*;

    // stretched reset for everything downstream
    logic              rst_int_n;
    // fifo to transmitter
    logic              tx_start;
    logic [DATA_W-1:0] tx_byte;
    logic              tx_busy;
    // receiver to decoder
    logic              rx_byte_valid;
    logic [DATA_W-1:0] rx_byte;

    reset_stretch #(
        .RST_CYCLES(RST_CYCLES)
    ) u_reset (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_rst_n (rst_int_n),
        .o_ready (o_ready)
    );

    // core writes queue here, credit back on each pop
    tx_credit_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .i_rst_n    (rst_int_n),
        .i_wr_valid (i_tx_valid),
        .i_wr_data  (i_tx_data),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .o_credit   (o_tx_credit)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk      (clk),
        .i_rst_n  (rst_int_n),
        .i_start  (tx_start),
        .i_byte   (tx_byte),
        .o_busy   (tx_busy),
        .o_serial (o_uart_tx)
    );

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk      (clk),
        .i_rst_n  (rst_int_n),
        .i_serial (i_uart_rx),
        .o_valid  (rx_byte_valid),
        .o_byte   (rx_byte)
    );

    // data back to the core, commands to the leds
    rx_cmd_decode u_decode (
        .clk        (clk),
        .i_rst_n    (rst_int_n),
        .i_valid    (rx_byte_valid),
        .i_byte     (rx_byte),
        .o_rx_valid (o_rx_valid),
        .o_rx_data  (o_rx_data),
        .o_led      (o_led)
    );

endmodule

// ==== verilog/rx_cmd_decode.sv ====
module rx_cmd_decode (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_valid,
    input  logic [uart_io_pkg::DATA_W-1:0] i_byte,
    output logic                           o_rx_valid,
    output logic [uart_io_pkg::DATA_W-1:0] o_rx_data,
    output logic [uart_io_pkg::LED_W-1:0]  o_led
);

    import uart_io_pkg::*;

    rx_word_u         word;
    logic             is_data;
    logic [LED_W-1:0] led_next;

    assign word = i_byte;

    // top bit clear means plain data
    assign is_data = !word.cmd.is_cmd;

    // led update per opcode
    always_comb
    begin
        case (word.cmd.op)
            OP_SET:    led_next = o_led | word.cmd.mask;
            OP_CLEAR:  led_next = o_led & ~word.cmd.mask;
            OP_TOGGLE: led_next = o_led ^ word.cmd.mask;
            OP_WRITE:  led_next = word.cmd.mask;
            default:   led_next = o_led;
        endcase
    end

    // data byte register
    always_ff @(posedge clk)
    begin
        if (i_valid && is_data)
        begin
            o_rx_data <= word.raw;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            o_rx_valid <= 1'b0;
            o_led      <= '0;
        end
        else
        begin
            // commands never reach the core
            o_rx_valid <= i_valid && is_data;
            if (i_valid && !is_data)
            begin
                o_led <= led_next;
            end
        end
    end

endmodule

// ==== verilog/uart_rx.sv ====
module uart_rx #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_serial,
    output logic                           o_valid,
    output logic [uart_io_pkg::DATA_W-1:0] o_byte
);

    import uart_io_pkg::*;

    localparam int               CNT_W     = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam int               IDX_W     = $clog2(DATA_W);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(DATA_W - 1);

    // fsm encoding
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]        sync;
    logic              rx_bit;
    logic [1:0]        state;
    logic [CNT_W-1:0]  clk_cnt;
    logic [IDX_W-1:0]  bit_idx;
    logic [DATA_W-1:0] shreg;
    logic              bit_end;
    logic              half_end;

    // synchronized line, second flop
    assign rx_bit = sync[1];

    assign bit_end  = (clk_cnt == CNT_LAST);
    assign half_end = (clk_cnt == HALF_LAST);

    // byte held until the next frame starts shifting
    assign o_byte = shreg;

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge clk)
    begin
        if (state == S_DATA && bit_end)
        begin
            shreg <= {rx_bit, shreg[DATA_W-1:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            sync    <= 2'b11;
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            sync    <= {sync[0], i_serial};
            o_valid <= 1'b0;
            // restart the count at each sample point
            if (state == S_IDLE || bit_end || (state == S_START && half_end))
            begin
                clk_cnt <= '0;
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            case (state)
                S_IDLE:
                begin
                    bit_idx <= '0;
                    // falling edge of start bit
                    if (!rx_bit)
                    begin
                        state <= S_START;
                    end
                end
                S_START:
                begin
                    // mid start bit, a glitch goes back to idle
                    if (half_end)
                    begin
                        state <= rx_bit ? S_IDLE : S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == IDX_LAST)
                        begin
                            state <= S_STOP;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default:
                begin
                    // framing error drops the byte
                    if (bit_end)
                    begin
                        o_valid <= rx_bit;
                        state   <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
module uart_tx #(
    parameter int CLKS_PER_BIT = 104
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_start,
    input  logic [uart_io_pkg::DATA_W-1:0] i_byte,
    output logic                           o_busy,
    output logic                           o_serial
);

    import uart_io_pkg::*;

    localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam int               IDX_W    = $clog2(DATA_W);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_W - 1);

    // fsm encoding
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]        state;
    logic [CNT_W-1:0]  clk_cnt;
    logic [IDX_W-1:0]  bit_idx;
    logic [DATA_W-1:0] shreg;
    logic              bit_end;

    // last cycle of the current bit
    assign bit_end = (clk_cnt == CNT_LAST);

    // busy through the whole frame, stop bit included
    assign o_busy = (state != S_IDLE);

    // byte latched on start, lsb shifted out first
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE)
        begin
            if (i_start)
            begin
                shreg <= i_byte;
            end
        end
        else if (bit_end && (state == S_START || state == S_DATA))
        begin
            shreg <= {1'b1, shreg[DATA_W-1:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            o_serial <= 1'b1;
        end
        else
        begin
            // bit period counter
            if (state == S_IDLE || bit_end)
            begin
                clk_cnt <= '0;
            end
            else
            begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            case (state)
                S_IDLE:
                begin
                    bit_idx <= '0;
                    if (i_start)
                    begin
                        // start bit
                        o_serial <= 1'b0;
                        state    <= S_START;
                    end
                end
                S_START:
                begin
                    if (bit_end)
                    begin
                        o_serial <= shreg[0];
                        state    <= S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == IDX_LAST)
                        begin
                            // stop bit
                            o_serial <= 1'b1;
                            state    <= S_STOP;
                        end
                        else
                        begin
                            bit_idx  <= bit_idx + 1'b1;
                            o_serial <= shreg[0];
                        end
                    end
                end
                default:
                begin
                    // stop bit held a full period
                    if (bit_end)
                    begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/tx_credit_fifo.sv ====
module tx_credit_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_wr_valid,
    input  logic [uart_io_pkg::DATA_W-1:0] i_wr_data,
    input  logic                           i_tx_busy,
    output logic                           o_tx_start,
    output logic [uart_io_pkg::DATA_W-1:0] o_tx_byte,
    output logic                           o_credit
);

    import uart_io_pkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int               PTR_W    = $clog2(FIFO_DEPTH);
    localparam int               CNT_W    = $clog2(FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              empty;
    logic              wr_ok;
    logic              rd_ok;
    logic              pop_q;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

    // write while full is dropped
    assign wr_ok = i_wr_valid && !full;

    // uart_tx raises busy one cycle after start
    // so pop_q blocks a second pop in that gap
    assign rd_ok = !empty && !i_tx_busy && !pop_q;

    // storage and outgoing byte
    always_ff @(posedge clk)
    begin
        if (wr_ok)
        begin
            mem[wr_ptr] <= i_wr_data;
        end
        if (rd_ok)
        begin
            o_tx_byte <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pop_q  <= 1'b0;
        end
        else
        begin
            pop_q <= rd_ok;
            if (wr_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy, unchanged on simultaneous push and pop
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // start and credit share the pop cycle, one credit per byte out
    assign o_tx_start = pop_q;
    assign o_credit   = pop_q;

endmodule

// ==== verilog/reset_stretch.sv ====
module reset_stretch #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk,
    input  logic i_rst_n,
    output logic o_rst_n,
    output logic o_ready
);

    localparam int               CNT_W   = $clog2(RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(RST_CYCLES);

    logic [CNT_W-1:0] cnt;
    logic             done;

    // saturation marks the end of the stretch
    assign done = (cnt == CNT_MAX);

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            cnt     <= '0;
            o_rst_n <= 1'b0;
            o_ready <= 1'b0;
        end
        else
        begin
            // count up until saturated, then hold
            if (!done)
            begin
                cnt <= cnt + 1'b1;
            end
            // both outputs registered from saturation
            o_rst_n <= done;
            o_ready <= done;
        end
    end

endmodule

// ==== verilog/uart_io_pkg.sv ====
package uart_io_pkg;

    // byte width on both serial paths
    localparam int DATA_W = 8;

    // led register width, also the command mask width
    localparam int LED_W = 4;

    // command opcodes, bits [6:5] of a command byte
    typedef enum logic [1:0] {
        OP_SET    = 2'd0,
        OP_CLEAR  = 2'd1,
        OP_TOGGLE = 2'd2,
        OP_WRITE  = 2'd3
    } cmd_op_e;

    // one received byte, read as plain data or as a command
    // top bit picks which view applies
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            // set for commands
            logic              is_cmd;
            cmd_op_e           op;
            // spare, ignored by the decoder
            logic              rsvd;
            logic [LED_W-1:0]  mask;
        } cmd;
    } rx_word_u;

endpackage
